//--- sim.f
+incdir+verilog
verilog/ldst_core_pkg.sv
verilog/ldst_bus_pkg.sv
verilog/ldst_reg_pop.sv
verilog/ldst_size_align.sv
verilog/ldst_control.sv
verilog/ldst_unit.sv
testbench/tb_ldst_checker.sv
testbench/tb_ldst_unit.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the load/store unit testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f sim.f \
	--top-module tb_ldst_unit \
	-o tb_ldst_unit

./obj_dir/tb_ldst_unit > sim.log 2>&1
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
	echo "simulation failed, see sim.log"
	exit 1
fi

echo "simulation passed"

//--- testbench/tb_ldst_unit.sv
`timescale 1ns/1ps
`include "ldst_settings.svh"

module tb_ldst_unit;

	import ldst_core_pkg::*;
	import ldst_bus_pkg::*;

	localparam int NUM_TESTS = 18;
	localparam int MAX_CYCLES = NUM_TESTS * 16 * 6 + 16 + 100;
	localparam word REG_PATTERN = 32'h1357_9bdf;

	logic            clk;
	logic            rst_n;
	logic            issue;
	ldst_req_t       req;
	logic            mem_ready;
	word             mem_rdata;
	word             store_value;
	logic            busy;
	logic            mem_start;
	mem_cmd_t        mem_cmd;
	reg_num          store_reg;
	logic            wb_valid;
	ldst_wb_t        wb;
	logic            base_wb_valid;
	word             base_wb;
	logic            fault;
	logic            done;
	logic [8*20-1:0] test_name;
	int              check_count;
	int              error_count;
	int              cycles = 0;
	word             mem [256];
	ldst_req_t       tests [NUM_TESTS];
	logic [8*20-1:0] names [NUM_TESTS];

	// register model, value is index times a pattern.
	assign store_value = word'(store_reg) * REG_PATTERN;

	ldst_unit u_ldst_unit (
		.clk           (clk),
		.rst_n         (rst_n),
		.issue         (issue),
		.req           (req),
		.mem_ready     (mem_ready),
		.mem_rdata     (mem_rdata),
		.store_value   (store_value),
		.busy          (busy),
		.mem_start     (mem_start),
		.mem_cmd       (mem_cmd),
		.store_reg     (store_reg),
		.wb_valid      (wb_valid),
		.wb            (wb),
		.base_wb_valid (base_wb_valid),
		.base_wb       (base_wb),
		.fault         (fault),
		.done          (done)
	);

	tb_ldst_checker u_checker (
		.clk           (clk),
		.rst_n         (rst_n),
		.test_name     (test_name),
		.issue         (issue),
		.req           (req),
		.busy          (busy),
		.mem_start     (mem_start),
		.mem_cmd       (mem_cmd),
		.mem_ready     (mem_ready),
		.wb_valid      (wb_valid),
		.wb            (wb),
		.base_wb_valid (base_wb_valid),
		.base_wb       (base_wb),
		.fault         (fault),
		.done          (done),
		.check_count   (check_count),
		.error_count   (error_count)
	);

	function automatic ldst_req_t make_req(word base, word offset, reg_list regs,
			ldst_size size, logic load, logic inc, logic pre, logic wback, logic sx);
		ldst_req_t r;
		r = '0;
		r.base = base;
		r.offset = offset;
		r.regs = regs;
		r.size = size;
		r.load = load;
		r.increment = inc;
		r.pre = pre;
		r.writeback = wback;
		r.sign_extend = sx;
		return r;
	endfunction

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: done was not seen within %0d cycles", MAX_CYCLES);
			$display("checks: %0d, errors: %0d", check_count, error_count);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	// memory model with a random 1 to 4 cycle answer.
	initial begin : memory_model
		int lat;
		int idx;
		void'($urandom(21));
		for (int i = 0; i < 256; i++)
			mem[i] = (i * 32'h9e37_79b9) ^ 32'h8c41_f026;
		mem_ready = 1'b0;
		mem_rdata = '0;
		forever begin
			@(negedge clk);
			if (rst_n && mem_start) begin
				lat = 1 + ($urandom % 4);
				@(posedge clk);
				repeat (lat - 1) @(posedge clk);
				#2;
				idx = int'(mem_cmd.addr[9:2]);
				mem_rdata = mem[idx];
				if (mem_cmd.write) begin
					for (int b = 0; b < 4; b++)
						if (mem_cmd.be[b])
							mem[idx][8*b +: 8] = mem_cmd.wdata[8*b +: 8];
				end
				mem_ready = 1'b1;
				@(posedge clk);
				#2 mem_ready = 1'b0;
			end
		end
	end

	initial begin : stimulus
		rst_n = 1'b0;
		issue = 1'b0;
		req = '0;
		test_name = "reset";
		names[0] = "ld_word_post";
		tests[0] = make_req(32'h100, 32'd4, 16'h0008, LDST_WORD, 1, 1, 0, 1, 0);
		names[1] = "st_word_pre";
		tests[1] = make_req(32'h200, 32'd8, 16'h0020, LDST_WORD, 0, 1, 1, 1, 0);
		names[2] = "ld_word_back";
		tests[2] = make_req(32'h208, 32'd0, 16'h0001, LDST_WORD, 1, 1, 0, 0, 0);
		names[3] = "ld_byte0_sx";
		tests[3] = make_req(32'h140, 32'd0, 16'h0002, LDST_BYTE, 1, 1, 0, 0, 1);
		names[4] = "ld_byte1_zx";
		tests[4] = make_req(32'h141, 32'd0, 16'h0002, LDST_BYTE, 1, 1, 0, 0, 0);
		names[5] = "ld_byte2_sx";
		tests[5] = make_req(32'h142, 32'd0, 16'h0002, LDST_BYTE, 1, 1, 0, 0, 1);
		names[6] = "ld_byte3_zx";
		tests[6] = make_req(32'h143, 32'd0, 16'h0002, LDST_BYTE, 1, 1, 0, 0, 0);
		names[7] = "ld_half0_sx";
		tests[7] = make_req(32'h14c, 32'd0, 16'h0004, LDST_HALF, 1, 1, 0, 0, 1);
		names[8] = "ld_half2_zx";
		tests[8] = make_req(32'h146, 32'd0, 16'h0004, LDST_HALF, 1, 1, 0, 0, 0);
		names[9] = "st_byte3";
		tests[9] = make_req(32'h303, 32'd0, 16'h0080, LDST_BYTE, 0, 1, 0, 0, 0);
		names[10] = "st_half2";
		tests[10] = make_req(32'h306, 32'd0, 16'h0200, LDST_HALF, 0, 1, 0, 0, 0);
		names[11] = "ld_multi_inc_wb";
		tests[11] = make_req(32'h180, 32'd4, 16'h00f1, LDST_WORD, 1, 1, 0, 1, 0);
		names[12] = "st_multi_inc_wb";
		tests[12] = make_req(32'h240, 32'd4, 16'h8421, LDST_WORD, 0, 1, 0, 1, 0);
		names[13] = "ld_multi_dec_pre";
		tests[13] = make_req(32'h1c0, -32'sd4, 16'h0e0a, LDST_WORD, 1, 0, 1, 1, 0);
		names[14] = "ld_half_misalign";
		tests[14] = make_req(32'h151, 32'd0, 16'h0004, LDST_HALF, 1, 1, 0, 1, 0);
		names[15] = "st_word_misalign";
		tests[15] = make_req(32'h152, 32'd0, 16'h0010, LDST_WORD, 0, 1, 0, 1, 0);
		names[16] = "empty_list";
		tests[16] = make_req(32'h100, 32'd4, 16'h0000, LDST_WORD, 1, 1, 0, 1, 0);
		names[17] = "ld_after_st";
		tests[17] = make_req(32'h304, 32'd0, 16'h0001, LDST_WORD, 1, 1, 0, 0, 0);

		// a few unprivileged accesses.
		tests[1].user = 1'b1;
		tests[13].user = 1'b1;

		repeat (16) @(posedge clk);
		#2 rst_n = 1'b1;

		for (int i = 0; i < NUM_TESTS; i++) begin
			@(posedge clk);
			#2;
			test_name = names[i];
			req = tests[i];
			issue = 1'b1;
			@(posedge clk);
			#2 issue = 1'b0;
			do @(negedge clk); while (!done);
		end

		repeat (4) @(posedge clk);
		$display("checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

//--- testbench/tb_ldst_checker.sv
`timescale 1ns/1ps
`include "ldst_settings.svh"

module tb_ldst_checker (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic [8*20-1:0]          test_name,
	input  logic                     issue,
	input  ldst_core_pkg::ldst_req_t req,
	input  logic                     busy,
	input  logic                     mem_start,
	input  ldst_bus_pkg::mem_cmd_t   mem_cmd,
	input  logic                     mem_ready,
	input  logic                     wb_valid,
	input  ldst_core_pkg::ldst_wb_t  wb,
	input  logic                     base_wb_valid,
	input  ldst_core_pkg::word       base_wb,
	input  logic                     fault,
	input  logic                     done,
	output int                       check_count,
	output int                       error_count
);

	import ldst_core_pkg::*;
	import ldst_bus_pkg::*;

	localparam word REG_PATTERN = 32'h1357_9bdf;

	word      shadow [256];
	word      exp_addr [$];
	mem_be    exp_be [$];
	word      exp_wdata [$];
	ldst_wb_t exp_wb [$];
	logic     exp_write;
	logic     exp_user;
	logic     exp_fault;
	logic     exp_base_valid;
	word      exp_base;
	logic     exp_busy;
	logic     step_due;
	logic     wb_due;
	logic     waiting;
	mem_cmd_t held_cmd;

	task automatic compare_value(string what, word expected, word actual);
		check_count++;
		if (expected !== actual) begin
			error_count++;
			$display("[ERROR] %0s %0s: expected %h actual %h", test_name, what, expected,
				actual);
		end
	endtask

	task automatic flag_problem(string msg);
		check_count++;
		error_count++;
		$display("%0s: %0s", test_name, msg);
	endtask

	// walks the list the way the unit should and queues each transfer.
	task automatic build_expected(ldst_req_t r);
		word    base;
		word    addr;
		word    value;
		word    sh;
		word    data;
		mem_be  be;
		int     idx;
		logic   bad;
		base = r.base;
		exp_fault = 1'b0;
		exp_write = !r.load;
		exp_user = r.user;
		for (int k = 0; k < `LDST_NUM_REGS; k++) begin
			idx = r.increment ? k : `LDST_NUM_REGS - 1 - k;
			if (r.regs[idx] && !exp_fault) begin
				addr = r.pre ? base + r.offset : base;
				value = word'(idx) * REG_PATTERN;
				sh = shadow[addr[9:2]] >> (8 * addr[1:0]);
				case (r.size)
					LDST_BYTE: begin
						bad = 1'b0;
						be = 4'b0001 << addr[1:0];
						data = {4{value[7:0]}};
						sh = r.sign_extend ? {{24{sh[7]}}, sh[7:0]} : {24'd0, sh[7:0]};
					end
					LDST_HALF: begin
						bad = addr[0];
						be = addr[1] ? 4'b1100 : 4'b0011;
						data = {2{value[15:0]}};
						sh = r.sign_extend ? {{16{sh[15]}}, sh[15:0]} : {16'd0, sh[15:0]};
					end
					default: begin
						bad = |addr[1:0];
						be = 4'b1111;
						data = value;
					end
				endcase
				if (bad) begin
					exp_fault = 1'b1;
				end else begin
					exp_addr.push_back(addr);
					exp_be.push_back(be);
					exp_wdata.push_back(data);
					if (r.load)
						exp_wb.push_back('{reg_idx: reg_num'(idx), value: sh});
					else
						for (int b = 0; b < 4; b++)
							if (be[b])
								shadow[addr[9:2]][8*b +: 8] = data[8*b +: 8];
					base = base + r.offset;
				end
			end
		end
		exp_base_valid = r.writeback && !exp_fault;
		exp_base = base;
	endtask

	// sampled on the falling edge, where DUT outputs have settled.
	always @(negedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 256; i++)
				shadow[i] = (i * 32'h9e37_79b9) ^ 32'h8c41_f026;
			exp_addr.delete();
			exp_be.delete();
			exp_wdata.delete();
			exp_wb.delete();
			exp_busy = 1'b0;
			step_due = 1'b0;
			wb_due = 1'b0;
			waiting = 1'b0;
			check_count = 0;
			error_count = 0;
		end else begin
			compare_value("busy", word'(exp_busy), word'(busy));
			if (step_due && !mem_start && !done)
				flag_problem("neither a transfer nor done followed issue or mem_ready");
			if (wb_due && !wb_valid)
				flag_problem("load data was not reported one cycle after mem_ready");
			step_due = 1'b0;
			wb_due = 1'b0;
			if (issue && !busy) begin
				build_expected(req);
				exp_busy = 1'b1;
				step_due = 1'b1;
			end
			if (mem_start) begin
				if (exp_addr.size() == 0) begin
					flag_problem("a transfer started that the request does not call for");
				end else begin
					compare_value("addr", exp_addr[0], mem_cmd.addr);
					compare_value("be", word'(exp_be[0]), word'(mem_cmd.be));
					compare_value("write", word'(exp_write), word'(mem_cmd.write));
					compare_value("user", word'(exp_user), word'(mem_cmd.user));
					if (exp_write)
						compare_value("wdata", exp_wdata[0], mem_cmd.wdata);
				end
				held_cmd = mem_cmd;
				waiting = 1'b1;
			end else if (waiting && mem_cmd !== held_cmd) begin
				flag_problem("mem_cmd changed while waiting for mem_ready");
			end
			if (waiting && mem_ready) begin
				waiting = 1'b0;
				step_due = 1'b1;
				wb_due = !exp_write;
				if (exp_addr.size() != 0) begin
					void'(exp_addr.pop_front());
					void'(exp_be.pop_front());
					void'(exp_wdata.pop_front());
				end
			end
			if (wb_valid) begin
				if (exp_wb.size() == 0) begin
					flag_problem("a register writeback came with none expected");
				end else begin
					compare_value("wb reg", word'(exp_wb[0].reg_idx), word'(wb.reg_idx));
					compare_value("wb value", exp_wb[0].value, wb.value);
					void'(exp_wb.pop_front());
				end
			end
			if (done) begin
				compare_value("fault", word'(exp_fault), word'(fault));
				compare_value("base_wb_valid", word'(exp_base_valid), word'(base_wb_valid));
				if (exp_base_valid)
					compare_value("base_wb", exp_base, base_wb);
				if (exp_addr.size() != 0 || exp_wb.size() != 0 || waiting)
					flag_problem("done came before all expected transfers finished");
				exp_addr.delete();
				exp_be.delete();
				exp_wdata.delete();
				exp_wb.delete();
				exp_busy = 1'b0;
			end
		end
	end

endmodule

//--- verilog/ldst_unit.sv
`timescale 1ns/1ps

module ldst_unit (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     issue,
	input  ldst_core_pkg::ldst_req_t req,
	input  logic                     mem_ready,
	input  ldst_core_pkg::word       mem_rdata,
	input  ldst_core_pkg::word       store_value,
	output logic                     busy,
	output logic                     mem_start,
	output ldst_bus_pkg::mem_cmd_t   mem_cmd,
	output ldst_core_pkg::reg_num    store_reg,
	output logic                     wb_valid,
	output ldst_core_pkg::ldst_wb_t  wb,
	output logic                     base_wb_valid,
	output ldst_core_pkg::word       base_wb,
	output logic                     fault,
	output logic                     done
);

	import ldst_core_pkg::*;
	import ldst_bus_pkg::*;

	reg_list  pending;
	reg_list  next_lower;
	reg_list  next_upper;
	reg_num   pop_lower;
	reg_num   pop_upper;
	logic     pop_valid;
	word      cur_addr;
	ldst_size cur_size;
	logic     cur_sign_extend;
	mem_be    align_be;
	word      align_wdata;
	word      align_read;
	logic     misaligned;

	ldst_reg_pop u_pop (
		.regs       (pending),
		.valid      (pop_valid),
		.pop_lower  (pop_lower),
		.pop_upper  (pop_upper),
		.next_lower (next_lower),
		.next_upper (next_upper)
	);

	ldst_size_align u_align (
		.addr        (cur_addr),
		.size        (cur_size),
		.sign_extend (cur_sign_extend),
		.store_value (store_value),
		.rdata       (mem_rdata),
		.be          (align_be),
		.wdata       (align_wdata),
		.read        (align_read),
		.misaligned  (misaligned)
	);

	ldst_control u_control (
		.clk             (clk),
		.rst_n           (rst_n),
		.issue           (issue),
		.req             (req),
		.mem_ready       (mem_ready),
		.pop_valid       (pop_valid),
		.pop_lower       (pop_lower),
		.pop_upper       (pop_upper),
		.next_lower      (next_lower),
		.next_upper      (next_upper),
		.align_be        (align_be),
		.align_wdata     (align_wdata),
		.align_read      (align_read),
		.misaligned      (misaligned),
		.pending         (pending),
		.cur_addr        (cur_addr),
		.cur_size        (cur_size),
		.cur_sign_extend (cur_sign_extend),
		.busy            (busy),
		.mem_start       (mem_start),
		.mem_cmd         (mem_cmd),
		.store_reg       (store_reg),
		.wb_valid        (wb_valid),
		.wb              (wb),
		.base_wb_valid   (base_wb_valid),
		.base_wb         (base_wb),
		.fault           (fault),
		.done            (done)
	);

endmodule

//--- verilog/ldst_control.sv
`timescale 1ns/1ps

module ldst_control (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     issue,
	input  ldst_core_pkg::ldst_req_t req,
	input  logic                     mem_ready,
	input  logic                     pop_valid,
	input  ldst_core_pkg::reg_num    pop_lower,
	input  ldst_core_pkg::reg_num    pop_upper,
	input  ldst_core_pkg::reg_list   next_lower,
	input  ldst_core_pkg::reg_list   next_upper,
	input  ldst_bus_pkg::mem_be      align_be,
	input  ldst_core_pkg::word       align_wdata,
	input  ldst_core_pkg::word       align_read,
	input  logic                     misaligned,
	output ldst_core_pkg::reg_list   pending,
	output ldst_core_pkg::word       cur_addr,
	output ldst_core_pkg::ldst_size  cur_size,
	output logic                     cur_sign_extend,
	output logic                     busy,
	output logic                     mem_start,
	output ldst_bus_pkg::mem_cmd_t   mem_cmd,
	output ldst_core_pkg::reg_num    store_reg,
	output logic                     wb_valid,
	output ldst_core_pkg::ldst_wb_t  wb,
	output logic                     base_wb_valid,
	output ldst_core_pkg::word       base_wb,
	output logic                     fault,
	output logic                     done
);

	import ldst_core_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_TRANSFER,
		ST_WAIT,
		ST_FINISH
	} state_t;

	state_t    state;
	state_t    state_next;
	ldst_req_t cur;
	reg_list   regs_left;
	logic      stop;
	logic      beat_done;

	// upward walks pop from the low end.
	assign store_reg = cur.increment ? pop_lower : pop_upper;
	assign regs_left = cur.increment ? next_lower : next_upper;

	assign pending = cur.regs;
	assign cur_addr = cur.pre ? cur.base + cur.offset : cur.base;
	assign cur_size = cur.size;
	assign cur_sign_extend = cur.sign_extend;

	// nothing left to move, or the address would fault.
	assign stop = !pop_valid || misaligned;
	assign beat_done = state == ST_WAIT && mem_ready;

	assign busy = state != ST_IDLE;
	assign mem_start = state == ST_TRANSFER && !stop;
	assign fault = state == ST_TRANSFER && pop_valid && misaligned;
	assign done = (state == ST_TRANSFER && stop) || state == ST_FINISH;

	// base already holds the stepped value here.
	assign base_wb_valid = done && !fault && cur.writeback;
	assign base_wb = cur.base;

	assign mem_cmd = '{
		addr:  cur_addr,
		be:    align_be,
		wdata: align_wdata,
		write: !cur.load,
		user:  cur.user
	};

	always_comb begin
		state_next = state;
		case (state)
			ST_IDLE:
				if (issue)
					state_next = ST_TRANSFER;
			ST_TRANSFER:
				state_next = stop ? ST_IDLE : ST_WAIT;
			ST_WAIT:
				if (mem_ready)
					state_next = (regs_left != '0) ? ST_TRANSFER : ST_FINISH;
			default:
				state_next = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			cur <= '0;
			wb_valid <= 1'b0;
		end else begin
			state <= state_next;
			wb_valid <= beat_done && cur.load;

			if (state == ST_IDLE && issue) begin
				cur <= req;
			end else if (beat_done) begin
				cur.base <= cur.base + cur.offset;
				cur.regs <= regs_left;
			end
		end
	end

	// read data of the beat just finished.
	always_ff @(posedge clk) begin
		if (beat_done) begin
			wb.reg_idx <= store_reg;
			wb.value <= align_read;
		end
	end

	a_one_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
		(mem_start || (state == ST_WAIT && !mem_ready)) |=> !mem_start)
	else
		$error("ldst_control: transfer started before mem_ready");

	a_cmd_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(state == ST_WAIT && !mem_ready) |=> $stable(mem_cmd))
	else
		$error("ldst_control: mem_cmd changed while waiting");

	// multiple transfers are word only.
	a_multi_word: assert property (@(posedge clk) disable iff (!rst_n)
		(issue && !busy && $countones(req.regs) > 1) |-> req.size == LDST_WORD)
	else
		$error("ldst_control: multiple transfer with sub-word size");

endmodule

//--- verilog/ldst_size_align.sv
`timescale 1ns/1ps
`include "ldst_settings.svh"

module ldst_size_align (
	input  ldst_core_pkg::word      addr,
	input  ldst_core_pkg::ldst_size size,
	input  logic                    sign_extend,
	input  ldst_core_pkg::word      store_value,
	input  ldst_core_pkg::word      rdata,
	output ldst_bus_pkg::mem_be     be,
	output ldst_core_pkg::word      wdata,
	output ldst_core_pkg::word      read,
	output logic                    misaligned
);

	import ldst_core_pkg::*;
	import ldst_bus_pkg::*;

	logic [1:0] lane;
	word        shifted;

	assign lane = addr[1:0];

	// bring the addressed lane down to bit 0.
	assign shifted = rdata >> {lane, 3'b000};

	always_comb begin
		case (size)
			LDST_BYTE: begin
				be = mem_be'(1) << lane;
				wdata = {(`LDST_WORD_W / 8){store_value[7:0]}};
				if (sign_extend)
					read = {{(`LDST_WORD_W - 8){shifted[7]}}, shifted[7:0]};
				else
					read = {{(`LDST_WORD_W - 8){1'b0}}, shifted[7:0]};
				misaligned = 1'b0;
			end
			LDST_HALF: begin
				be = lane[1] ? 4'b1100 : 4'b0011;
				wdata = {(`LDST_WORD_W / 16){store_value[15:0]}};
				if (sign_extend)
					read = {{(`LDST_WORD_W - 16){shifted[15]}}, shifted[15:0]};
				else
					read = {{(`LDST_WORD_W - 16){1'b0}}, shifted[15:0]};
				// odd halfword address.
				misaligned = lane[0];
			end
			default: begin
				be = '1;
				wdata = store_value;
				read = rdata;
				misaligned = |lane;
			end
		endcase
	end

endmodule

//--- verilog/ldst_reg_pop.sv
`timescale 1ns/1ps
`include "ldst_settings.svh"

module ldst_reg_pop (
	input  ldst_core_pkg::reg_list regs,
	output logic                   valid,
	output ldst_core_pkg::reg_num  pop_lower,
	output ldst_core_pkg::reg_num  pop_upper,
	output ldst_core_pkg::reg_list next_lower,
	output ldst_core_pkg::reg_list next_upper
);

	import ldst_core_pkg::*;

	assign valid = |regs;

	// walking up, the last hit is the highest set bit.
	always_comb begin
		pop_upper = '0;
		for (int i = 0; i < `LDST_NUM_REGS; i++) begin
			if (regs[i])
				pop_upper = reg_num'(i);
		end
	end

	// walking down, the last hit is the lowest set bit.
	always_comb begin
		pop_lower = '0;
		for (int i = `LDST_NUM_REGS - 1; i >= 0; i--) begin
			if (regs[i])
				pop_lower = reg_num'(i);
		end
	end

	always_comb begin
		next_lower = regs;
		next_upper = regs;
		next_lower[pop_lower] = 1'b0;
		next_upper[pop_upper] = 1'b0;
	end

	// each pop takes exactly one register off the list.
	always_comb begin
		if (valid) begin
			assert ($countones(next_lower) == $countones(regs) - 1)
			else
				$error("ldst_reg_pop: lower pop did not remove one register");
			assert ($countones(next_upper) == $countones(regs) - 1)
			else
				$error("ldst_reg_pop: upper pop did not remove one register");
		end
	end

endmodule

//--- verilog/ldst_bus_pkg.sv
`include "ldst_settings.svh"

package ldst_bus_pkg;

	typedef logic [`LDST_BE_W-1:0] mem_be;

	// one memory transfer, held until mem_ready.
	typedef struct packed {
		ldst_core_pkg::word addr;
		mem_be              be;
		ldst_core_pkg::word wdata;
		logic               write;
		logic               user;
	} mem_cmd_t;

endpackage

//--- verilog/ldst_core_pkg.sv
`include "ldst_settings.svh"

package ldst_core_pkg;

	typedef logic [`LDST_WORD_W-1:0] word;

	// one bit per register, bit n is register n.
	typedef logic [`LDST_NUM_REGS-1:0] reg_list;

	typedef logic [`LDST_REG_NUM_W-1:0] reg_num;

	typedef enum logic [1:0] {
		LDST_BYTE = 2'd0,
		LDST_HALF = 2'd1,
		LDST_WORD = 2'd2
	} ldst_size;

	// decoded load/store as handed over by the core.
	typedef struct packed {
		word      base;
		word      offset;
		reg_list  regs;
		ldst_size size;
		logic     load;
		logic     increment;
		logic     pre;
		logic     writeback;
		logic     sign_extend;
		logic     user;
	} ldst_req_t;

	// loaded register report.
	typedef struct packed {
		reg_num reg_idx;
		word    value;
	} ldst_wb_t;

endpackage

//--- verilog/ldst_settings.svh
`ifndef LDST_SETTINGS_SVH
`define LDST_SETTINGS_SVH

// data and address width.
`define LDST_WORD_W 32

// one enable per byte lane.
`define LDST_BE_W (`LDST_WORD_W / 8)

// architectural register count.
`define LDST_NUM_REGS 16

// index width for the register list.
`define LDST_REG_NUM_W 4

`endif
